// File: project.f
+incdir+.
rob_pkg.sv
rob_if.sv
rob_ptr_ctr.sv
rob_entry_file.sv
rob_commit_fsm.sv
rob_top.sv
tb_rob.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the reorder buffer testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_rob -f project.f -o Vtb_rob
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1

// File: tb_rob.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module tb_rob;

    localparam logic [1:0] EV_NONE  = 2'd0;
    localparam logic [1:0] EV_WB    = 2'd1;
    localparam logic [1:0] EV_STORE = 2'd2;
    localparam logic [1:0] EV_FLUSH = 2'd3;

    // rough cycle length of reset and each test
    localparam int TEST_CYCLES = 16 + 100 + 150 + 60 + 60 + 60 + 60;

    typedef struct packed {
        logic [`NICK_W-1:0] nick;
        logic [`REG_W-1:0]  rd;
        logic               is_store;
        logic               pred;
        logic               done;
        logic               taken;
        logic [`DATA_W-1:0] data;
        logic [`ADDR_W-1:0] target;
    } model_ent_t;

    typedef struct packed {
        logic [1:0]         kind;
        logic [`NICK_W-1:0] nick;
        logic [`REG_W-1:0]  rd;
        logic [`DATA_W-1:0] data;
        logic [`ADDR_W-1:0] pc;
    } commit_t;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic               clr_in;
    logic               alloc_req;
    logic [`REG_W-1:0]  alloc_rd;
    logic               alloc_is_store;
    logic               alloc_pred;
    logic               alloc_ok;
    logic [`NICK_W-1:0] alloc_nick;
    logic               cdb_valid;
    logic [`NICK_W-1:0] cdb_nick;
    logic [`DATA_W-1:0] cdb_data;
    logic               cdb_taken;
    logic [`ADDR_W-1:0] cdb_target;
    logic               store_done;
    logic               rf_we;
    logic [`REG_W-1:0]  rf_rd;
    logic [`DATA_W-1:0] rf_data;
    logic [`NICK_W-1:0] rf_nick;
    logic               store_go;
    logic [`NICK_W-1:0] store_nick;
    logic               flush_out;
    logic [`ADDR_W-1:0] redirect_pc;
    logic               full;

    // program order model with the head at index 0
    model_ent_t         model [$];
    logic [`NICK_W-1:0] nk [16];
    logic [`NICK_W-1:0] exp_tail = `NICK_W'(1);
    logic               store_pending = 1'b0;
    logic [31:0]        rng = 32'd17;
    int                 err_cnt = 0;
    int                 err_mark = 0;
    int                 pass_cnt = 0;
    int                 fail_cnt = 0;
    int                 wb_cnt = 0;
    int                 store_cnt = 0;
    int                 flush_cnt = 0;

    rob_top dut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rnd();
        rng = xorshift(rng);
        return rng;
    endfunction

    // tags wrap from the last slot back to 1
    function automatic logic [`NICK_W-1:0] next_nick(input logic [`NICK_W-1:0] n);
        if (n == `NICK_W'(`ROB_DEPTH - 1)) begin
            return `NICK_W'(1);
        end
        return n + `NICK_W'(1);
    endfunction

    // what the head of the model must do next
    function automatic commit_t expect_commit();
        commit_t    ev;
        model_ent_t h;
        ev = '0;
        ev.kind = EV_NONE;
        if (model.size() == 0) begin
            return ev;
        end
        h = model[0];
        ev.nick = h.nick;
        if (h.is_store) begin
            ev.kind = EV_STORE;
        end else if (h.done && h.pred != h.taken) begin
            ev.kind = EV_FLUSH;
            ev.pc   = h.target;
        end else if (h.done) begin
            ev.kind = EV_WB;
            ev.rd   = h.rd;
            ev.data = h.data;
        end
        return ev;
    endfunction

    function automatic void mark_done(input logic [`NICK_W-1:0] nick,
                                      input logic [`DATA_W-1:0] d,
                                      input logic taken,
                                      input logic [`ADDR_W-1:0] t);
        model_ent_t e;
        foreach (model[i]) begin
            if (model[i].nick == nick) begin
                e        = model[i];
                e.done   = 1'b1;
                e.data   = d;
                e.taken  = taken;
                e.target = t;
                model[i] = e;
            end
        end
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got 0x%0h exp 0x%0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            $display("test %s: pass", name);
            pass_cnt++;
        end else begin
            $display("test %s: fail with %0d errors", name, err_cnt - err_mark);
            fail_cnt++;
        end
        err_mark = err_cnt;
    endtask

    // holds req until granted, then drops it on the next falling edge
    task automatic alloc_one(input logic st, input logic pd, output logic [`NICK_W-1:0] nick);
        model_ent_t e;
        @(negedge clk);
        alloc_req      = 1'b1;
        alloc_rd       = `REG_W'(rnd());
        alloc_is_store = st;
        alloc_pred     = pd;
        #1;
        while (!alloc_ok) begin
            @(negedge clk);
            #1;
        end
        check("alloc_nick", 32'(alloc_nick), 32'(exp_tail));
        e          = '0;
        e.nick     = exp_tail;
        e.rd       = alloc_rd;
        e.is_store = st;
        e.pred     = pd;
        model.push_back(e);
        nick     = alloc_nick;
        exp_tail = next_nick(exp_tail);
        @(negedge clk);
        alloc_req = 1'b0;
    endtask

    task automatic complete(input logic [`NICK_W-1:0] nick, input logic taken);
        logic [`DATA_W-1:0] d;
        logic [`ADDR_W-1:0] t;
        d = rnd();
        t = rnd();
        @(negedge clk);
        cdb_valid  = 1'b1;
        cdb_nick   = nick;
        cdb_data   = d;
        cdb_taken  = taken;
        cdb_target = t;
        mark_done(nick, d, taken, t);
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic complete_shuffled(input int lo, input int n);
        int                 j;
        logic [`NICK_W-1:0] t;
        for (int i = n - 1; i > 0; i--) begin
            j = int'(rnd() % 32'(i + 1));
            t = nk[lo + i];
            nk[lo + i] = nk[lo + j];
            nk[lo + j] = t;
        end
        for (int i = 0; i < n; i++) begin
            complete(nk[lo + i], 1'b0);
        end
    endtask

    task automatic drain();
        while (model.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin : compare
        commit_t ev;
        forever begin
            @(posedge clk);
            ev = expect_commit();
            if (!rst && rf_we) begin
                check("commit kind on rf_we", 32'(EV_WB), 32'(ev.kind));
                check("rf_rd", 32'(rf_rd), 32'(ev.rd));
                check("rf_data", 32'(rf_data), 32'(ev.data));
                check("rf_nick", 32'(rf_nick), 32'(ev.nick));
                if (model.size() > 0) begin
                    model.delete(0);
                end
                wb_cnt++;
            end
            if (!rst && store_go) begin
                check("commit kind on store_go", 32'(EV_STORE), 32'(ev.kind));
                check("store_nick", 32'(store_nick), 32'(ev.nick));
                check("store_go while waiting", 32'(store_pending), 32'd0);
                store_pending = 1'b1;
                store_cnt++;
            end
            if (!rst && flush_out) begin
                check("commit kind on flush_out", 32'(EV_FLUSH), 32'(ev.kind));
                check("redirect_pc", 32'(redirect_pc), 32'(ev.pc));
                // younger entries are squashed
                model.delete();
                exp_tail = `NICK_W'(1);
                flush_cnt++;
            end
        end
    end

    initial begin : watchdog
        repeat (TEST_CYCLES * 4) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 4);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        logic [`NICK_W-1:0] n0;
        int                 w0;
        int                 s0;
        int                 f0;
        int                 delay;
        rst            = 1'b1;
        rdy            = 1'b1;
        clr_in         = 1'b0;
        alloc_req      = 1'b0;
        alloc_rd       = '0;
        alloc_is_store = 1'b0;
        alloc_pred     = 1'b0;
        cdb_valid      = 1'b0;
        cdb_nick       = '0;
        cdb_data       = '0;
        cdb_taken      = 1'b0;
        cdb_target     = '0;
        store_done     = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        #1;
        check("rf_we after reset", 32'(rf_we), 32'd0);
        check("store_go after reset", 32'(store_go), 32'd0);
        check("flush_out after reset", 32'(flush_out), 32'd0);
        check("full after reset", 32'(full), 32'd0);
        end_test("reset values");

        w0 = wb_cnt;
        for (int i = 0; i < 10; i++) begin
            alloc_one(1'b0, 1'b0, nk[i]);
        end
        complete_shuffled(0, 10);
        drain();
        check("retire count", 32'(wb_cnt - w0), 32'd10);
        end_test("out of order completion");

        // the oldest of the fifteen is the tag freed first
        n0 = exp_tail;
        for (int i = 0; i < 15; i++) begin
            alloc_one(1'b0, 1'b0, nk[i]);
        end
        @(negedge clk);
        alloc_req = 1'b1;
        #1;
        check("full", 32'(full), 32'd1);
        check("alloc_ok when full", 32'(alloc_ok), 32'd0);
        // free the head while the request stays up
        complete(nk[0], 1'b0);
        alloc_one(1'b0, 1'b0, nk[15]);
        check("reused nick", 32'(nk[15]), 32'(n0));
        complete_shuffled(1, 15);
        drain();
        end_test("full and wrap");

        w0 = wb_cnt;
        s0 = store_cnt;
        alloc_one(1'b1, 1'b0, nk[0]);
        alloc_one(1'b0, 1'b0, nk[1]);
        alloc_one(1'b0, 1'b0, nk[2]);
        complete(nk[2], 1'b0);
        complete(nk[1], 1'b0);
        while (!store_pending) begin
            @(negedge clk);
        end
        delay = 2 + int'(rnd() % 32'd8);
        repeat (delay) @(negedge clk);
        check("retire during store wait", 32'(wb_cnt - w0), 32'd0);
        store_done = 1'b1;
        model.delete(0);
        store_pending = 1'b0;
        @(negedge clk);
        store_done = 1'b0;
        drain();
        check("store count", 32'(store_cnt - s0), 32'd1);
        check("retire count", 32'(wb_cnt - w0), 32'd2);
        end_test("store handoff");

        w0 = wb_cnt;
        f0 = flush_cnt;
        // branch predicted not taken that resolves taken
        alloc_one(1'b0, 1'b0, nk[0]);
        alloc_one(1'b0, 1'b0, nk[1]);
        alloc_one(1'b0, 1'b0, nk[2]);
        complete(nk[1], 1'b0);
        complete(nk[2], 1'b0);
        complete(nk[0], 1'b1);
        while (flush_cnt == f0) begin
            @(negedge clk);
        end
        alloc_one(1'b0, 1'b0, n0);
        check("nick after flush", 32'(n0), 32'd1);
        complete(n0, 1'b0);
        drain();
        check("retire count", 32'(wb_cnt - w0), 32'd1);
        end_test("mispredict flush");

        w0 = wb_cnt;
        f0 = flush_cnt;
        alloc_one(1'b0, 1'b1, nk[0]);
        complete(nk[0], 1'b1);
        drain();
        check("retire count", 32'(wb_cnt - w0), 32'd1);
        alloc_one(1'b0, 1'b0, nk[1]);
        alloc_one(1'b0, 1'b0, nk[2]);
        @(negedge clk);
        clr_in = 1'b1;
        model.delete();
        exp_tail = `NICK_W'(1);
        @(negedge clk);
        clr_in = 1'b0;
        repeat (4) @(negedge clk);
        check("flush count", 32'(flush_cnt - f0), 32'd0);
        alloc_one(1'b0, 1'b0, n0);
        check("nick after clear", 32'(n0), 32'd1);
        complete(n0, 1'b0);
        drain();
        end_test("predicted branch and clear");

        w0 = wb_cnt;
        alloc_one(1'b0, 1'b0, nk[0]);
        alloc_one(1'b0, 1'b0, nk[1]);
        complete(nk[1], 1'b0);
        complete(nk[0], 1'b0);
        // freeze while the done head waits to retire
        rdy       = 1'b0;
        alloc_req = 1'b1;
        repeat (6) begin
            #1;
            check("alloc_ok while frozen", 32'(alloc_ok), 32'd0);
            check("rf_we while frozen", 32'(rf_we), 32'd0);
            @(negedge clk);
        end
        rdy       = 1'b1;
        alloc_req = 1'b0;
        drain();
        check("retire count", 32'(wb_cnt - w0), 32'd2);
        end_test("freeze on rdy low");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rob_top.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr_in,
    input  logic               alloc_req,
    input  logic [`REG_W-1:0]  alloc_rd,
    input  logic               alloc_is_store,
    input  logic               alloc_pred,
    output logic               alloc_ok,
    output logic [`NICK_W-1:0] alloc_nick,
    input  logic               cdb_valid,
    input  logic [`NICK_W-1:0] cdb_nick,
    input  logic [`DATA_W-1:0] cdb_data,
    input  logic               cdb_taken,
    input  logic [`ADDR_W-1:0] cdb_target,
    input  logic               store_done,
    output logic               rf_we,
    output logic [`REG_W-1:0]  rf_rd,
    output logic [`DATA_W-1:0] rf_data,
    output logic [`NICK_W-1:0] rf_nick,
    output logic               store_go,
    output logic [`NICK_W-1:0] store_nick,
    output logic               flush_out,
    output logic [`ADDR_W-1:0] redirect_pc,
    output logic               full
);

    alloc_if alloc_bus ();
    cdb_if   cdb_bus ();

    logic                pop;
    logic                retire;
    logic                flush;
    logic                in_flush;
    logic [`NICK_W-1:0]  head;
    logic                empty;
    rob_pkg::rob_entry_t head_entry;

    // no grants during the flush cycle, so ok stays low with it
    assign alloc_bus.req      = alloc_req && !in_flush;
    assign alloc_bus.rd       = alloc_rd;
    assign alloc_bus.is_store = alloc_is_store;
    assign alloc_bus.pred     = alloc_pred;
    assign alloc_ok           = alloc_bus.ok;
    assign alloc_nick         = alloc_bus.nick;

    assign cdb_bus.valid  = cdb_valid;
    assign cdb_bus.nick   = cdb_nick;
    assign cdb_bus.data   = cdb_data;
    assign cdb_bus.taken  = cdb_taken;
    assign cdb_bus.target = cdb_target;

    rob_ptr_ctr u_ptr_ctr (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .clr_in (clr_in),
        .pop    (pop),
        .flush  (flush),
        .alloc  (alloc_bus.ctr),
        .head   (head),
        .tail   (),
        .count  (),
        .full   (full),
        .empty  (empty)
    );

    rob_entry_file u_entry_file (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .clr_in     (clr_in),
        .flush      (flush),
        .retire     (retire),
        .head       (head),
        .alloc      (alloc_bus.file),
        .cdb        (cdb_bus.sink),
        .head_entry (head_entry)
    );

    rob_commit_fsm u_commit_fsm (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr_in      (clr_in),
        .head        (head),
        .empty       (empty),
        .head_entry  (head_entry),
        .store_done  (store_done),
        .pop         (pop),
        .retire      (retire),
        .flush       (flush),
        .in_flush    (in_flush),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .rf_nick     (rf_nick),
        .store_go    (store_go),
        .store_nick  (store_nick),
        .flush_out   (flush_out),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: rob_commit_fsm.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_commit_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                clr_in,
    input  logic [`NICK_W-1:0]  head,
    input  logic                empty,
    input  rob_pkg::rob_entry_t head_entry,
    input  logic                store_done,
    output logic                pop,
    output logic                retire,
    output logic                flush,
    output logic                in_flush,
    output logic                rf_we,
    output logic [`REG_W-1:0]   rf_rd,
    output logic [`DATA_W-1:0]  rf_data,
    output logic [`NICK_W-1:0]  rf_nick,
    output logic                store_go,
    output logic [`NICK_W-1:0]  store_nick,
    output logic                flush_out,
    output logic [`ADDR_W-1:0]  redirect_pc
);

    rob_pkg::commit_state_e state, state_nx;

    logic head_live;
    logic do_wb;
    logic do_store;
    logic do_flush;
    logic store_fin;

    assign head_live = !empty && head_entry.occupied;

    // decisions only made from the commit state
    assign do_wb = rdy && state == rob_pkg::ST_COMMIT && head_live && head_entry.done
                   && !head_entry.is_store
                   && (head_entry.pred_taken == head_entry.act_taken);
    assign do_flush = rdy && state == rob_pkg::ST_COMMIT && head_live && head_entry.done
                      && !head_entry.is_store
                      && (head_entry.pred_taken != head_entry.act_taken);
    // stores need no cdb result, hand off as soon as they reach the head
    assign do_store = rdy && state == rob_pkg::ST_COMMIT && head_live && head_entry.is_store;
    assign store_fin = rdy && state == rob_pkg::ST_STORE_WAIT && store_done;

    assign pop      = do_wb || store_fin;
    assign retire   = do_wb || store_fin;
    assign flush    = do_flush;
    assign in_flush = (state == rob_pkg::ST_FLUSH);

    always_comb begin
        state_nx = state;
        case (state)
            rob_pkg::ST_COMMIT: begin
                if (do_flush) begin
                    state_nx = rob_pkg::ST_FLUSH;
                end else if (do_store) begin
                    state_nx = rob_pkg::ST_STORE_WAIT;
                end
            end
            rob_pkg::ST_STORE_WAIT: begin
                if (store_fin) begin
                    state_nx = rob_pkg::ST_COMMIT;
                end
            end
            // one cycle, pointers are already back at 1
            rob_pkg::ST_FLUSH: begin
                if (rdy) begin
                    state_nx = rob_pkg::ST_COMMIT;
                end
            end
            default: state_nx = rob_pkg::ST_COMMIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr_in) begin
            state     <= rob_pkg::ST_COMMIT;
            rf_we     <= 1'b0;
            store_go  <= 1'b0;
            flush_out <= 1'b0;
        end else begin
            // pulses drop while frozen
            state     <= state_nx;
            rf_we     <= do_wb;
            store_go  <= do_store;
            flush_out <= do_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wb) begin
            rf_rd   <= head_entry.rd;
            rf_data <= head_entry.data;
            rf_nick <= head;
        end
        if (do_store) begin
            store_nick <= head;
        end
        if (do_flush) begin
            redirect_pc <= head_entry.target;
        end
    end

    a_store_done_in_wait: assert property (@(posedge clk) disable iff (rst || clr_in)
        store_done |-> state == rob_pkg::ST_STORE_WAIT);

    a_wb_flush_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rf_we && flush_out));

endmodule

// File: rob_entry_file.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_entry_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr_in,
    input  logic               flush,
    input  logic               retire,
    input  logic [`NICK_W-1:0] head,
    alloc_if.file              alloc,
    cdb_if.sink                cdb,
    output rob_pkg::rob_entry_t head_entry
);

    rob_pkg::rob_entry_t ent [`ROB_DEPTH];

    logic alloc_fire;

    assign alloc_fire = alloc.req && alloc.ok;

    // head slot is read combinationally by the commit logic
    assign head_entry = ent[head];

    always_ff @(posedge clk) begin
        if (rst || clr_in || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ent[i].occupied <= 1'b0;
                ent[i].done     <= 1'b0;
            end
        end else if (rdy) begin
            if (alloc_fire) begin
                ent[alloc.nick].occupied   <= 1'b1;
                ent[alloc.nick].done       <= 1'b0;
                ent[alloc.nick].is_store   <= alloc.is_store;
                ent[alloc.nick].pred_taken <= alloc.pred;
                ent[alloc.nick].rd         <= alloc.rd;
            end

            // out of order results
            if (cdb.valid) begin
                ent[cdb.nick].done      <= 1'b1;
                ent[cdb.nick].data      <= cdb.data;
                ent[cdb.nick].act_taken <= cdb.taken;
                ent[cdb.nick].target    <= cdb.target;
            end

            // last so it wins on the head slot
            if (retire) begin
                ent[head].occupied <= 1'b0;
                ent[head].done     <= 1'b0;
            end
        end
    end

    // completion must name a live slot, never the null nick
    a_cdb_hits_live_slot: assert property (@(posedge clk) disable iff (rst || clr_in)
        (cdb.valid && rdy) |-> (cdb.nick != '0 && ent[cdb.nick].occupied));

endmodule

// File: rob_ptr_ctr.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_ptr_ctr (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr_in,
    input  logic               pop,
    input  logic               flush,
    alloc_if.ctr               alloc,
    output logic [`NICK_W-1:0] head,
    output logic [`NICK_W-1:0] tail,
    output logic [`NICK_W-1:0] count,
    output logic               full,
    output logic               empty
);

    localparam logic [`NICK_W-1:0] LAST = `NICK_W'(`ROB_DEPTH - 1);

    logic push;

    // wrap past the last slot back to 1, never 0
    function automatic logic [`NICK_W-1:0] next_ptr(input logic [`NICK_W-1:0] p);
        return (p == LAST) ? `NICK_W'(1) : p + `NICK_W'(1);
    endfunction

    function automatic logic [`NICK_W-1:0] ptr_add(input logic [`NICK_W-1:0] p,
                                                   input logic [`NICK_W-1:0] n);
        int s;
        s = (int'(p) - 1 + int'(n)) % (`ROB_DEPTH - 1);
        return `NICK_W'(s + 1);
    endfunction

    assign full  = (count == LAST);
    assign empty = (count == '0);

    assign alloc.ok   = alloc.req && !full && rdy;
    assign alloc.nick = alloc.ok ? tail : '0;

    assign push = alloc.req && alloc.ok;

    always_ff @(posedge clk) begin
        if (rst || clr_in || flush) begin
            head  <= `NICK_W'(1);
            tail  <= `NICK_W'(1);
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + `NICK_W'(1);
                2'b01:   count <= count - `NICK_W'(1);
                default: count <= count;
            endcase
        end
    end

    // occupancy stays in step with the pointer distance
    a_count_matches_ptrs: assert property (@(posedge clk) disable iff (rst)
        tail == ptr_add(head, count));

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// File: rob_if.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// decode asks for a slot, the pointer counter grants it
interface alloc_if;
    logic              req;
    logic [`REG_W-1:0] rd;
    logic              is_store;
    logic              pred;
    logic              ok;
    logic [`NICK_W-1:0] nick;

    // grant side
    modport ctr (
        input  req,
        output ok,
        output nick
    );

    // entry file only watches the handshake
    modport file (
        input req,
        input rd,
        input is_store,
        input pred,
        input ok,
        input nick
    );

    modport src (
        output req,
        output rd,
        output is_store,
        output pred,
        input  ok,
        input  nick
    );
endinterface

// completion broadcast from execution
interface cdb_if;
    logic               valid;
    logic [`NICK_W-1:0] nick;
    logic [`DATA_W-1:0] data;
    logic               taken;
    logic [`ADDR_W-1:0] target;

    modport sink (
        input valid,
        input nick,
        input data,
        input taken,
        input target
    );
endinterface

// File: rob_pkg.sv
`include "rob_defs.svh"

package rob_pkg;

    // one reorder buffer slot
    typedef struct packed {
        logic               occupied;
        logic               done;
        logic               is_store;
        logic               pred_taken;
        // filled in by the cdb
        logic               act_taken;
        logic [`REG_W-1:0]  rd;
        logic [`DATA_W-1:0] data;
        // jal needs both data and target, so no overlap
        logic [`ADDR_W-1:0] target;
    } rob_entry_t;

    // commit side state machine
    typedef enum logic [1:0] {
        ST_COMMIT     = 2'd0,
        ST_STORE_WAIT = 2'd1,
        ST_FLUSH      = 2'd2
    } commit_state_e;

endpackage

// File: rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// slot 0 is reserved as the null nick
`define ROB_DEPTH 16

// nick (tag) width, wide enough for ROB_DEPTH-1
`define NICK_W 4

// result word
`define DATA_W 32

// pc and branch target
`define ADDR_W 32

// architectural register name
`define REG_W 5

`endif
